/* design/rv_pkg.sv */
package rv_pkg;

    parameter int xlen = 64;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_xor,
        alu_sltu,
        alu_sra,
        alu_sll_w
    } alu_op_e;

    typedef enum logic {
        src_reg,
        src_imm
    } alu_src_e;

    // decoded control of one instruction
    typedef struct packed {
        logic              reg_wen;
        reg_addr_t         rd;
        reg_addr_t         rs1;
        reg_addr_t         rs2;
        alu_op_e           alu_op;
        alu_src_e          alu_src;
        logic [xlen-1:0]   imm;     // already sign extended
        logic              word_op; // 32-bit result, sign extended
        logic              illegal;
        logic              halt;
    } ctrl_t;

    // one retired instruction
    typedef struct packed {
        reg_addr_t         rd;
        logic [xlen-1:0]   value;
        logic              wrote;   // a register really changed
        logic              illegal;
        logic              halt;
    } result_t;

endpackage

/* design/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::inst_t inst,
    output rv_pkg::ctrl_t ctrl
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] shamt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{(rv_pkg::xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u  = {{(rv_pkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};
    assign shamt  = {{(rv_pkg::xlen-6){1'b0}}, inst[25:20]}; // 6-bit shamt on rv64

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = inst[11:7];
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.alu_op  = rv_pkg::alu_add;
        ctrl.alu_src = rv_pkg::src_reg;
        ctrl.imm     = imm_i;
        case (opcode)
            7'b0110011: begin // r-type
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0000000) begin
                            ctrl.alu_op = rv_pkg::alu_add;
                        end else if (funct7 == 7'b0100000) begin
                            ctrl.alu_op = rv_pkg::alu_sub;
                        end else begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                    3'b111:  ctrl.alu_op = rv_pkg::alu_and;
                    3'b011:  ctrl.alu_op = rv_pkg::alu_sltu;
                    default: ctrl.illegal = 1'b1;
                endcase
                if (funct3 != 3'b000 && funct7 != 7'b0000000) begin
                    ctrl.illegal = 1'b1;
                end
            end
            7'b0010011: begin // i-type alu
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_pkg::src_imm;
                case (funct3)
                    3'b000:  ctrl.alu_op = rv_pkg::alu_add;
                    3'b011:  ctrl.alu_op = rv_pkg::alu_sltu;
                    3'b111:  ctrl.alu_op = rv_pkg::alu_and;
                    3'b100:  ctrl.alu_op = rv_pkg::alu_xor;
                    3'b101: begin
                        ctrl.alu_op  = rv_pkg::alu_sra;
                        ctrl.imm     = shamt;
                        ctrl.illegal = (inst[31:26] != 6'b010000); // srli not kept
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b0110111: begin // lui, x0 + imm
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = '0;
                ctrl.alu_src = rv_pkg::src_imm;
                ctrl.imm     = imm_u;
            end
            7'b0111011: begin // addw, sllw
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    ctrl.alu_op = rv_pkg::alu_add;
                end else if (funct3 == 3'b001 && funct7 == 7'b0000000) begin
                    ctrl.alu_op = rv_pkg::alu_sll_w;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            7'b0011011: begin // addiw
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                ctrl.alu_src = rv_pkg::src_imm;
                ctrl.illegal = (funct3 != 3'b000);
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin
                    ctrl.halt = 1'b1; // ebreak
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.reg_wen = 1'b0;
        end
    end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         op,
    input  logic                    word_op,
    output logic [rv_pkg::xlen-1:0] y
);

    logic [5:0]              shamt;
    logic [rv_pkg::xlen-1:0] raw;

    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add:   raw = a + b;
            rv_pkg::alu_sub:   raw = a - b;
            rv_pkg::alu_and:   raw = a & b;
            rv_pkg::alu_xor:   raw = a ^ b;
            rv_pkg::alu_sltu:  raw = {{(rv_pkg::xlen-1){1'b0}}, (a < b)};
            rv_pkg::alu_sra:   raw = $signed(a) >>> shamt;
            rv_pkg::alu_sll_w: raw = a << shamt; // upper bits dropped below
            default:           raw = a + b;
        endcase
    end

    // word ops keep the low half, sign extended
    assign y = word_op ? {{(rv_pkg::xlen-32){raw[31]}}, raw[31:0]} : raw;

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::reg_addr_t       raddr1,
    input  rv_pkg::reg_addr_t       raddr2,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2,
    input  logic                    wen,
    input  rv_pkg::reg_addr_t       waddr,
    input  logic [rv_pkg::xlen-1:0] wdata
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign dout    = mem[rd_ptr]; // show-ahead head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

endmodule

/* design/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter #(
    parameter int INIT = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       take,
    input  logic                       give,
    output logic [$clog2(INIT+1)-1:0]  count,
    output logic                       avail
);

    localparam int CW = $clog2(INIT + 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= CW'(INIT);
        end else begin
            count <= count + CW'(give) - CW'(take); // both may arrive together
        end
    end

    assign avail = (count != '0);

endmodule

/* design/exec_sequencer.sv */
`timescale 1ns/1ps

module exec_sequencer (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_empty,
    input  logic          res_full,
    output logic          pop,
    output logic          reg_we,
    output logic          push,
    input  rv_pkg::ctrl_t ctrl
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_retire
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   stage_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            stage_wen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (pop) begin
                stage_wen <= ctrl.reg_wen && !ctrl.illegal; // carried to retire
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (!in_empty) state_nxt = st_exec;
            end
            st_exec: state_nxt = st_retire;
            st_retire: begin
                if (!res_full) state_nxt = in_empty ? st_idle : st_exec; // hold while full
            end
            default: state_nxt = st_idle;
        endcase
    end

    assign pop    = (state == st_exec);
    assign push   = (state == st_retire) && !res_full;
    assign reg_we = push && stage_wen;

endmodule

/* design/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  rv_pkg::inst_t   in_inst,
    output logic            in_credit,
    output logic            res_valid,
    output rv_pkg::result_t res,
    input  logic            res_credit
);

    rv_pkg::inst_t           in_head;
    rv_pkg::ctrl_t           ctrl;
    rv_pkg::result_t         stage_res;
    logic                    in_empty;
    logic                    res_empty;
    logic                    res_full;
    logic                    pop;
    logic                    push;
    logic                    reg_we;
    logic                    out_avail;
    logic [rv_pkg::xlen-1:0] rdata1;
    logic [rv_pkg::xlen-1:0] rdata2;
    logic [rv_pkg::xlen-1:0] alu_b;
    logic [rv_pkg::xlen-1:0] alu_y;

    credit_fifo #(.payload_t(rv_pkg::inst_t), .DEPTH(IN_DEPTH)) i_in_fifo (
        .clk(clk), .rst(rst), .push(in_valid), .din(in_inst), .pop(pop),
        .dout(in_head), .empty(in_empty), .full()
    );

    exec_sequencer i_seq (
        .clk(clk), .rst(rst), .in_empty(in_empty), .res_full(res_full),
        .pop(pop), .reg_we(reg_we), .push(push), .ctrl(ctrl)
    );

    rv_decoder i_dec (.inst(in_head), .ctrl(ctrl));

    rv_regfile i_rf (
        .clk(clk), .rst(rst), .raddr1(ctrl.rs1), .raddr2(ctrl.rs2),
        .rdata1(rdata1), .rdata2(rdata2),
        .wen(reg_we), .waddr(stage_res.rd), .wdata(stage_res.value)
    );

    assign alu_b = (ctrl.alu_src == rv_pkg::src_imm) ? ctrl.imm : rdata2;

    rv_alu i_alu (.a(rdata1), .b(alu_b), .op(ctrl.alu_op), .word_op(ctrl.word_op), .y(alu_y));

    // exec/retire stage, loaded as the instruction leaves the input fifo
    always_ff @(posedge clk) begin
        if (pop) begin
            stage_res.rd      <= ctrl.rd;
            stage_res.value   <= ctrl.reg_wen ? alu_y : '0;
            stage_res.wrote   <= ctrl.reg_wen && (ctrl.rd != '0);
            stage_res.illegal <= ctrl.illegal;
            stage_res.halt    <= ctrl.halt;
        end
    end

    credit_fifo #(.payload_t(rv_pkg::result_t), .DEPTH(OUT_DEPTH)) i_res_fifo (
        .clk(clk), .rst(rst), .push(push), .din(stage_res), .pop(res_valid),
        .dout(res), .empty(res_empty), .full(res_full)
    );

    credit_counter #(.INIT(OUT_CREDITS)) i_out_credits (
        .clk(clk), .rst(rst), .take(res_valid), .give(res_credit),
        .count(), .avail(out_avail)
    );

    assign res_valid = !res_empty && out_avail;
    assign in_credit = pop; // one credit back per popped instruction

endmodule

/* tb/rv_exec_chk.sv */
`timescale 1ns/1ps

module rv_exec_chk #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_credit,
    input logic pop,
    input logic push,
    input logic res_valid,
    input logic res_credit
);

    int in_level;  // entries in the input fifo
    int res_level; // entries in the result fifo
    int sent;
    int returned;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_level  <= 0;
            res_level <= 0;
            sent      <= 0;
            returned  <= 0;
        end else begin
            in_level  <= in_level + int'(in_valid) - int'(pop);
            res_level <= res_level + int'(push) - int'(res_valid);
            sent      <= sent + int'(res_valid);
            returned  <= returned + int'(res_credit);
        end
    end

    a_in_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> in_level < IN_DEPTH)
        else $error("input fifo pushed while full");

    a_in_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> in_level > 0)
        else $error("input fifo popped while empty");

    a_res_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> res_level < OUT_DEPTH)
        else $error("result fifo pushed while full");

    a_res_no_underflow: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> res_level > 0)
        else $error("result sent from an empty fifo");

    a_res_credit_bound: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> sent < returned + OUT_CREDITS)
        else $error("result sent beyond the returned credits");

    a_in_credit_pulse: assert property (@(posedge clk) disable iff (rst)
        in_credit |=> !in_credit)
        else $error("in_credit held longer than one cycle");

endmodule

bind rv_exec_top rv_exec_chk #(
    .IN_DEPTH(IN_DEPTH),
    .OUT_DEPTH(OUT_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
) i_chk (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_credit(in_credit),
    .pop(pop), .push(push),
    .res_valid(res_valid), .res_credit(res_credit)
);

/* tb/tb_rv_exec.sv */
`timescale 1ns/1ps

module tb_rv_exec;

    typedef enum int {
        k_add, k_sub, k_and, k_sltu,
        k_addi, k_sltiu, k_andi, k_xori, k_srai, k_lui,
        k_addw, k_sllw, k_addiw,
        k_ebreak, k_ld, k_mul
    } kind_e;

    logic            clk;
    logic            rst;
    logic            in_valid;
    rv_pkg::inst_t   in_inst;
    logic            in_credit;
    logic            res_valid;
    rv_pkg::result_t res;
    logic            res_credit;

    logic [15:0]     lfsr;
    logic [63:0]     model_regs [32];
    rv_pkg::inst_t   prog [$];
    rv_pkg::result_t want_q [$];
    string           name_q [$];
    logic            prog_built;
    int              in_credits;    // upstream credits in hand
    int              credit_pulses;
    int              issued;
    int              valid_cycles;
    int              returned;
    int              owed;          // results taken, credit not yet sent back
    int              hold;

    rv_exec_top #(.IN_DEPTH(4), .OUT_DEPTH(4), .OUT_CREDITS(2)) i_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_inst(in_inst),
        .in_credit(in_credit), .res_valid(res_valid), .res(res), .res_credit(res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rv_pkg::inst_t encode(input kind_e k, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [19:0] imm);
        case (k)
            k_add:    return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
            k_sub:    return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
            k_and:    return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
            k_sltu:   return {7'h00, rs2, rs1, 3'b011, rd, 7'h33};
            k_addi:   return {imm[11:0], rs1, 3'b000, rd, 7'h13};
            k_sltiu:  return {imm[11:0], rs1, 3'b011, rd, 7'h13};
            k_andi:   return {imm[11:0], rs1, 3'b111, rd, 7'h13};
            k_xori:   return {imm[11:0], rs1, 3'b100, rd, 7'h13};
            k_srai:   return {6'b010000, imm[5:0], rs1, 3'b101, rd, 7'h13};
            k_lui:    return {imm, rd, 7'h37};
            k_addw:   return {7'h00, rs2, rs1, 3'b000, rd, 7'h3b};
            k_sllw:   return {7'h00, rs2, rs1, 3'b001, rd, 7'h3b};
            k_addiw:  return {imm[11:0], rs1, 3'b000, rd, 7'h1b};
            k_ebreak: return 32'h0010_0073;
            k_mul:    return {7'h01, rs2, rs1, 3'b000, rd, 7'h33}; // m extension, not kept
            default:  return {imm[11:0], rs1, 3'b011, rd, 7'h03}; // ld
        endcase
    endfunction

    function automatic logic [63:0] model_value(input kind_e k, input logic [63:0] a,
                                                input logic [63:0] b, input logic [19:0] imm);
        logic [63:0] i12;
        i12 = {{52{imm[11]}}, imm[11:0]};
        case (k)
            k_add:   return a + b;
            k_sub:   return a - b;
            k_and:   return a & b;
            k_sltu:  return (a < b) ? 64'd1 : 64'd0;
            k_addi:  return a + i12;
            k_sltiu: return (a < i12) ? 64'd1 : 64'd0;
            k_andi:  return a & i12;
            k_xori:  return a ^ i12;
            k_srai:  return $signed(a) >>> imm[5:0];
            k_lui:   return {{32{imm[19]}}, imm, 12'h000};
            k_addw:  return 64'($signed(32'(a[31:0] + b[31:0])));
            k_sllw:  return 64'($signed(32'(a[31:0] << b[4:0])));
            k_addiw: return 64'($signed(32'(a[31:0] + i12[31:0])));
            default: return 64'd0;
        endcase
    endfunction

    task automatic emit(input kind_e k, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [19:0] imm, input string name);
        rv_pkg::result_t r;
        r         = '0;
        r.illegal = (k == k_ld) || (k == k_mul);
        r.halt    = (k == k_ebreak);
        r.rd      = r.halt ? 5'd0 : rd;
        r.wrote   = !r.illegal && !r.halt && (rd != 5'd0);
        if (!r.illegal && !r.halt) begin
            r.value = model_value(k, model_regs[rs1], model_regs[rs2], imm);
        end
        if (r.wrote) begin
            model_regs[rd] = r.value;
        end
        prog.push_back(encode(k, rd, rs1, rs2, imm));
        want_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic emit_random(input kind_e k, input string name);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [19:0] imm;
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        rs2 = 5'(take_bits(5));
        imm = 20'(take_bits(20));
        emit(k, rd, rs1, rs2, imm, name);
    endtask

    task automatic build_program();
        for (int r = 1; r < 32; r++) begin
            emit(k_lui, 5'(r), 5'd0, 5'd0, 20'(take_bits(20)), "seed");
            emit(k_xori, 5'(r), 5'(r), 5'd0, 20'(take_bits(12)), "seed");
        end
        repeat (24) emit_random(kind_e'(take_bits(2)), "r_type");
        repeat (30) emit_random(kind_e'(4 + take_bits(3) % 6), "i_type");
        repeat (18) emit_random(kind_e'(10 + take_bits(2) % 3), "word_op");
        emit(k_add, 5'd0, 5'd5, 5'd6, 20'd0, "x0_write");
        emit(k_addi, 5'd0, 5'd7, 5'd0, 20'h00123, "x0_write");
        emit(k_add, 5'd9, 5'd0, 5'd0, 20'd0, "x0_read");
        emit(k_sub, 5'd10, 5'd11, 5'd0, 20'd0, "x0_read");
        emit(k_ld, 5'd12, 5'd3, 5'd0, 20'h00010, "illegal");
        emit(k_mul, 5'd13, 5'd4, 5'd5, 20'd0, "illegal");
        emit(k_addi, 5'd14, 5'd12, 5'd0, 20'd0, "illegal"); // x12 and x13 untouched
        emit(k_add, 5'd15, 5'd13, 5'd0, 20'd0, "illegal");
        emit(k_ebreak, 5'd0, 5'd0, 5'd0, 20'd0, "ebreak");
        repeat (16) emit_random(kind_e'(take_bits(4) % 13), "mixed");
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    initial begin
        wait (prog_built);
        repeat (200 * prog.size()) @(posedge clk);
        fail_run("watchdog expired with results still missing");
    end

    initial begin
        rv_pkg::result_t want;
        string           test;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_inst       = '0;
        res_credit    = 1'b0;
        lfsr          = 16'd8424;
        prog_built    = 1'b0;
        in_credits    = 4;
        credit_pulses = 0;
        issued        = 0;
        valid_cycles  = 0;
        returned      = 0;
        owed          = 0;
        hold          = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        prog_built = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (want_q.size() != 0) begin
            @(negedge clk);
            if (res_valid) begin
                valid_cycles++;
                owed++;
                want = want_q.pop_front();
                test = name_q.pop_front();
                assert (valid_cycles <= returned + 2)
                    else fail_run("result sent without an output credit");
                assert (res == want)
                    else fail_run($sformatf("Error %s expected %h actual %h", test, want, res));
            end
            res_credit = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if (owed > 0) begin
                res_credit = 1'b1;
                owed--;
                returned++;
                // one return in eight opens a long stall
                hold = (take_bits(3) == 0) ? 16 + int'(take_bits(5)) : int'(take_bits(2));
            end
            in_valid = 1'b0;
            if (in_credits > 0 && issued < prog.size() && take_bits(2) != 0) begin
                in_valid = 1'b1;
                in_inst  = prog[issued];
                issued++;
                in_credits--;
            end
            if (in_credit) begin // usable from the next cycle
                in_credits++;
                credit_pulses++;
            end
            assert (credit_pulses <= issued)
                else fail_run("in_credit pulsed with no instruction outstanding");
        end
        in_valid   = 1'b0;
        res_credit = 1'b0;
        repeat (4) @(negedge clk);
        assert (!res_valid && credit_pulses == issued && issued == prog.size())
            else fail_run("in_credit pulses or results do not match the instructions accepted");
        $display("** PASS **");
        $finish;
    end

endmodule

/* build.f */
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/credit_fifo.sv
design/credit_counter.sv
design/exec_sequencer.sv
design/rv_exec_top.sv
tb/rv_exec_chk.sv
tb/tb_rv_exec.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_exec -f build.f
	./obj_dir/Vtb_rv_exec | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
